/* rtl/bridge_pkg.sv */
package bridge_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0] bus_addr_t;
    typedef logic [DATA_WIDTH-1:0] bus_data_t;
    typedef logic [7:0]            ascii_t;

    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_COMMAND,
        ERR_HEX
    } parse_err_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cmd_op_t;

    // request from the parser to the bus master
    typedef struct packed {
        logic      valid;
        cmd_op_t   op;
        bus_addr_t addr;
        bus_data_t data;
    } bus_req_t;

    typedef struct packed {
        logic      valid;
        logic      timeout;
        bus_data_t data;
    } bus_result_t;

    localparam ascii_t CHAR_MARK    = "?";
    localparam ascii_t CHAR_READ    = "r";
    localparam ascii_t CHAR_WRITE   = "w";
    localparam ascii_t CHAR_NEWLINE = 8'h0a;

    function automatic logic hex_valid(ascii_t c);
        return (c >= "0" && c <= "9") ||
               (c >= "A" && c <= "F") ||
               (c >= "a" && c <= "f");
    endfunction

    // only meaningful when hex_valid is true
    function automatic logic [3:0] hex_value(ascii_t c);
        ascii_t v;
        if (c >= "a") begin
            v = c - "a" + 8'd10;
        end else if (c >= "A") begin
            v = c - "A" + 8'd10;
        end else begin
            v = c - "0";
        end
        return v[3:0];
    endfunction

    function automatic ascii_t hex_char(logic [3:0] n);
        if (n < 4'd10) begin
            return ascii_t'("0" + {4'd0, n});
        end
        return ascii_t'("A" + {4'd0, n} - 8'd10);
    endfunction

endpackage

/* rtl/command_parser.sv */
`timescale 1ns/1ps

module command_parser (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  bridge_pkg::ascii_t     rx_byte_i,
    input  logic                   rx_valid_i,
    output logic                   rx_ready_o,
    input  logic                   reply_done_i,
    output bridge_pkg::bus_req_t   req_o,
    output bridge_pkg::parse_err_t parse_err_o
);

    typedef enum logic [2:0] {
        ST_MARK,
        ST_CMD,
        ST_ADDR,
        ST_DATA,
        ST_WAIT
    } state_t;

    localparam int AW = bridge_pkg::ADDR_WIDTH;
    localparam int DW = bridge_pkg::DATA_WIDTH;

    state_t                 state_q;
    logic [1:0]             digit_q;
    logic                   req_valid_q;
    bridge_pkg::parse_err_t err_q;
    bridge_pkg::cmd_op_t    op_q;
    bridge_pkg::bus_addr_t  addr_q;
    bridge_pkg::bus_data_t  data_q;
    logic                   rx_take;
    logic                   is_hex;
    logic [3:0]             nibble;

    // blocked while a command is being served
    assign rx_ready_o = (state_q != ST_WAIT);
    assign rx_take    = rx_valid_i && rx_ready_o;
    assign is_hex     = bridge_pkg::hex_valid(rx_byte_i);
    assign nibble     = bridge_pkg::hex_value(rx_byte_i);

    assign req_o = '{valid: req_valid_q, op: op_q, addr: addr_q, data: data_q};
    assign parse_err_o = err_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q     <= ST_MARK;
            digit_q     <= '0;
            req_valid_q <= 1'b0;
            err_q       <= bridge_pkg::ERR_NONE;
        end else begin
            req_valid_q <= 1'b0;
            err_q       <= bridge_pkg::ERR_NONE;
            case (state_q)
                ST_MARK: begin
                    if (rx_take && rx_byte_i == bridge_pkg::CHAR_MARK) begin
                        state_q <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    if (rx_take) begin
                        digit_q <= '0;
                        if (rx_byte_i == bridge_pkg::CHAR_READ ||
                            rx_byte_i == bridge_pkg::CHAR_WRITE) begin
                            state_q <= ST_ADDR;
                        end else begin
                            err_q   <= bridge_pkg::ERR_COMMAND;
                            state_q <= ST_WAIT;
                        end
                    end
                end
                ST_ADDR: begin
                    if (rx_take) begin
                        if (!is_hex) begin
                            err_q   <= bridge_pkg::ERR_HEX;
                            state_q <= ST_WAIT;
                        end else if (digit_q == 2'd3) begin
                            digit_q <= '0;
                            if (op_q == bridge_pkg::OP_WRITE) begin
                                state_q <= ST_DATA;
                            end else begin
                                req_valid_q <= 1'b1;
                                state_q     <= ST_WAIT;
                            end
                        end else begin
                            digit_q <= digit_q + 2'd1;
                        end
                    end
                end
                ST_DATA: begin
                    if (rx_take) begin
                        if (!is_hex) begin
                            err_q   <= bridge_pkg::ERR_HEX;
                            state_q <= ST_WAIT;
                        end else if (digit_q == 2'd1) begin
                            req_valid_q <= 1'b1;
                            state_q     <= ST_WAIT;
                        end else begin
                            digit_q <= digit_q + 2'd1;
                        end
                    end
                end
                ST_WAIT: begin
                    if (reply_done_i) begin
                        state_q <= ST_MARK;
                    end
                end
                default: state_q <= ST_MARK;
            endcase
        end
    end

    // opcode, address and data shift in as characters arrive
    always_ff @(posedge clk_i) begin
        if (rx_take) begin
            case (state_q)
                ST_CMD: begin
                    op_q <= (rx_byte_i == bridge_pkg::CHAR_WRITE) ?
                            bridge_pkg::OP_WRITE : bridge_pkg::OP_READ;
                end
                ST_ADDR: addr_q <= {addr_q[AW-5:0], nibble};
                ST_DATA: data_q <= {data_q[DW-5:0], nibble};
                default: ;
            endcase
        end
    end

endmodule

/* rtl/wb_single_master.sv */
`timescale 1ns/1ps

module wb_single_master #(
    parameter int MAX_WAIT = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  bridge_pkg::bus_req_t                req_i,
    output bridge_pkg::bus_result_t             result_o,
    output bridge_pkg::bus_addr_t               adr_o,
    output bridge_pkg::bus_data_t               dat_o,
    output logic                                we_o,
    output logic [bridge_pkg::DATA_WIDTH/8-1:0] sel_o,
    output logic                                stb_o,
    output logic                                cyc_o,
    input  bridge_pkg::bus_data_t               dat_i,
    input  logic                                ack_i
);

    typedef enum logic {
        M_IDLE,
        M_BUS
    } state_t;

    localparam int CNT_W = $clog2(MAX_WAIT + 1);

    state_t                state_q;
    logic [CNT_W-1:0]      wait_q;
    logic                  we_q;
    logic                  res_valid_q;
    logic                  timeout_q;
    bridge_pkg::bus_addr_t adr_q;
    bridge_pkg::bus_data_t wdata_q;
    bridge_pkg::bus_data_t rdata_q;

    assign cyc_o = (state_q == M_BUS);
    assign stb_o = cyc_o;
    assign we_o  = we_q;
    assign adr_o = adr_q;
    assign dat_o = wdata_q;
    assign sel_o = '1;

    assign result_o = '{valid: res_valid_q, timeout: timeout_q, data: rdata_q};

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q     <= M_IDLE;
            wait_q      <= '0;
            we_q        <= 1'b0;
            res_valid_q <= 1'b0;
            timeout_q   <= 1'b0;
        end else begin
            res_valid_q <= 1'b0;
            case (state_q)
                M_IDLE: begin
                    if (req_i.valid) begin
                        state_q <= M_BUS;
                        we_q    <= (req_i.op == bridge_pkg::OP_WRITE);
                        wait_q  <= '0;
                    end
                end
                M_BUS: begin
                    if (ack_i) begin
                        state_q     <= M_IDLE;
                        we_q        <= 1'b0;
                        res_valid_q <= 1'b1;
                        timeout_q   <= 1'b0;
                    end else if (wait_q == CNT_W'(MAX_WAIT - 1)) begin
                        // slave never answered
                        state_q     <= M_IDLE;
                        we_q        <= 1'b0;
                        res_valid_q <= 1'b1;
                        timeout_q   <= 1'b1;
                    end else begin
                        wait_q <= wait_q + 1'b1;
                    end
                end
                default: state_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == M_IDLE && req_i.valid) begin
            adr_q   <= req_i.addr;
            wdata_q <= req_i.data;
        end
        if (state_q == M_BUS && ack_i) begin
            rdata_q <= dat_i;
        end
    end

endmodule

/* rtl/reply_writer.sv */
`timescale 1ns/1ps

module reply_writer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  bridge_pkg::bus_result_t result_i,
    input  bridge_pkg::parse_err_t  parse_err_i,
    input  bridge_pkg::cmd_op_t     op_i,
    output bridge_pkg::ascii_t      tx_byte_o,
    output logic                    tx_valid_o,
    input  logic                    tx_ready_i,
    output logic                    reply_done_o
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_HEX,
        W_TEXT,
        W_NEWLINE
    } state_t;

    typedef enum logic [1:0] {
        MSG_OK,
        MSG_NO_RESP,
        MSG_CMD_ERR,
        MSG_HEX_ONLY
    } msg_t;

    state_t                state_q;
    msg_t                  msg_q;
    logic [3:0]            idx_q;
    bridge_pkg::bus_data_t rdata_q;
    logic                  tx_take;

    // messages are left aligned in nine character slots
    function automatic bridge_pkg::ascii_t text_char(msg_t m, logic [3:0] i);
        logic [71:0] txt;
        case (m)
            MSG_OK:      txt = "OK       ";
            MSG_NO_RESP: txt = "no resp! ";
            MSG_CMD_ERR: txt = "cmd err! ";
            default:     txt = "hex only!";
        endcase
        return txt[8*(8-i) +: 8];
    endfunction

    function automatic logic [3:0] text_last(msg_t m);
        case (m)
            MSG_OK:       return 4'd1;
            MSG_HEX_ONLY: return 4'd8;
            default:      return 4'd7;
        endcase
    endfunction

    assign tx_valid_o   = (state_q != W_IDLE);
    assign tx_take      = tx_valid_o && tx_ready_i;
    assign reply_done_o = (state_q == W_NEWLINE) && tx_ready_i;

    always_comb begin
        tx_byte_o = bridge_pkg::CHAR_NEWLINE;
        case (state_q)
            W_HEX: begin
                tx_byte_o = bridge_pkg::hex_char(idx_q[0] ? rdata_q[3:0] : rdata_q[7:4]);
            end
            W_TEXT:  tx_byte_o = text_char(msg_q, idx_q);
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q <= W_IDLE;
            msg_q   <= MSG_OK;
            idx_q   <= '0;
        end else begin
            case (state_q)
                W_IDLE: begin
                    idx_q <= '0;
                    if (result_i.valid) begin
                        if (result_i.timeout) begin
                            msg_q   <= MSG_NO_RESP;
                            state_q <= W_TEXT;
                        end else if (op_i == bridge_pkg::OP_READ) begin
                            state_q <= W_HEX;
                        end else begin
                            msg_q   <= MSG_OK;
                            state_q <= W_TEXT;
                        end
                    end else if (parse_err_i != bridge_pkg::ERR_NONE) begin
                        msg_q   <= (parse_err_i == bridge_pkg::ERR_COMMAND) ?
                                   MSG_CMD_ERR : MSG_HEX_ONLY;
                        state_q <= W_TEXT;
                    end
                end
                W_HEX: begin
                    if (tx_take) begin
                        if (idx_q == 4'd1) begin
                            state_q <= W_NEWLINE;
                        end else begin
                            idx_q <= idx_q + 4'd1;
                        end
                    end
                end
                W_TEXT: begin
                    if (tx_take) begin
                        if (idx_q == text_last(msg_q)) begin
                            state_q <= W_NEWLINE;
                        end else begin
                            idx_q <= idx_q + 4'd1;
                        end
                    end
                end
                W_NEWLINE: begin
                    if (tx_take) begin
                        state_q <= W_IDLE;
                    end
                end
                default: state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == W_IDLE && result_i.valid) begin
            rdata_q <= result_i.data;
        end
    end

endmodule

/* rtl/wb_debug_bridge.sv */
`timescale 1ns/1ps

module wb_debug_bridge #(
    parameter int MAX_WAIT = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  bridge_pkg::ascii_t                  rx_byte_i,
    input  logic                                rx_valid_i,
    output logic                                rx_ready_o,
    output bridge_pkg::ascii_t                  tx_byte_o,
    output logic                                tx_valid_o,
    input  logic                                tx_ready_i,
    output bridge_pkg::bus_addr_t               adr_o,
    output bridge_pkg::bus_data_t               dat_o,
    output logic                                we_o,
    output logic [bridge_pkg::DATA_WIDTH/8-1:0] sel_o,
    output logic                                stb_o,
    output logic                                cyc_o,
    input  bridge_pkg::bus_data_t               dat_i,
    input  logic                                ack_i
);

    bridge_pkg::bus_req_t    req;
    bridge_pkg::bus_result_t result;
    bridge_pkg::parse_err_t  parse_err;
    logic                    reply_done;

    command_parser u_parser (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rx_byte_i    (rx_byte_i),
        .rx_valid_i   (rx_valid_i),
        .rx_ready_o   (rx_ready_o),
        .reply_done_i (reply_done),
        .req_o        (req),
        .parse_err_o  (parse_err)
    );

    wb_single_master #(
        .MAX_WAIT (MAX_WAIT)
    ) u_master (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req),
        .result_o (result),
        .adr_o    (adr_o),
        .dat_o    (dat_o),
        .we_o     (we_o),
        .sel_o    (sel_o),
        .stb_o    (stb_o),
        .cyc_o    (cyc_o),
        .dat_i    (dat_i),
        .ack_i    (ack_i)
    );

    // opcode stays latched in the parser until the reply is done
    reply_writer u_writer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .result_i     (result),
        .parse_err_i  (parse_err),
        .op_i         (req.op),
        .tx_byte_o    (tx_byte_o),
        .tx_valid_o   (tx_valid_o),
        .tx_ready_i   (tx_ready_i),
        .reply_done_o (reply_done)
    );

endmodule

/* testbench/tb_wb_debug_bridge.sv */
`timescale 1ns/1ps

module tb_wb_debug_bridge;

    localparam int MAX_WAIT     = 8;
    localparam int NUM_CMDS     = 200;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = NUM_CMDS * 150;
    localparam int RAND_SEED    = 26;

    logic                                clk_i;
    logic                                rst_i;
    bridge_pkg::ascii_t                  rx_byte_i;
    logic                                rx_valid_i;
    logic                                rx_ready_o;
    bridge_pkg::ascii_t                  tx_byte_o;
    logic                                tx_valid_o;
    logic                                tx_ready_i;
    bridge_pkg::bus_addr_t               adr_o;
    bridge_pkg::bus_data_t               dat_o;
    logic                                we_o;
    logic [bridge_pkg::DATA_WIDTH/8-1:0] sel_o;
    logic                                stb_o;
    logic                                cyc_o;
    bridge_pkg::bus_data_t               dat_i;
    logic                                ack_i;

    // slave storage, kept up to date by the reference model
    bridge_pkg::bus_data_t mem [0:65535];
    bridge_pkg::ascii_t    exp_q[$];

    int                    cycles;
    int                    error_count;
    int unsigned           seed_ret;
    logic                  sending;
    logic                  bus_expected;
    logic                  exp_we;
    bridge_pkg::bus_addr_t exp_adr;
    bridge_pkg::bus_data_t exp_dat;
    logic                  slave_busy;
    int                    ack_delay;
    logic                  have_write;
    bridge_pkg::bus_addr_t last_write_addr;

    wb_debug_bridge #(
        .MAX_WAIT (MAX_WAIT)
    ) dut_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rx_byte_i  (rx_byte_i),
        .rx_valid_i (rx_valid_i),
        .rx_ready_o (rx_ready_o),
        .tx_byte_o  (tx_byte_o),
        .tx_valid_o (tx_valid_o),
        .tx_ready_i (tx_ready_i),
        .adr_o      (adr_o),
        .dat_o      (dat_o),
        .we_o       (we_o),
        .sel_o      (sel_o),
        .stb_o      (stb_o),
        .cyc_o      (cyc_o),
        .dat_i      (dat_i),
        .ack_i      (ack_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run(string why);
        error_count++;
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_char(bridge_pkg::ascii_t got, bridge_pkg::ascii_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: tx_byte_o is %h, expected %h", $time, got, exp);
            abort_run("reply character mismatch");
        end
    endtask

    task automatic check_bus_write(bridge_pkg::bus_addr_t got_adr,
                                   bridge_pkg::bus_data_t got_dat,
                                   bridge_pkg::bus_addr_t want_adr,
                                   bridge_pkg::bus_data_t want_dat);
        if (got_adr !== want_adr) begin
            $display("Error at time %0t: adr_o is %h, expected %h", $time, got_adr, want_adr);
            abort_run("bus write address mismatch");
        end else if (got_dat !== want_dat) begin
            $display("Error at time %0t: dat_o is %h, expected %h", $time, got_dat, want_dat);
            abort_run("bus write data mismatch");
        end
    endtask

    task automatic check_bus_addr(bridge_pkg::bus_addr_t got, bridge_pkg::bus_addr_t want);
        if (got !== want) begin
            $display("Error at time %0t: adr_o is %h, expected %h", $time, got, want);
            abort_run("bus address mismatch");
        end
    endtask

    task automatic check_sel(logic [bridge_pkg::DATA_WIDTH/8-1:0] got);
        logic [bridge_pkg::DATA_WIDTH/8-1:0] want;
        want = '1;
        if (got !== want) begin
            $display("Error at time %0t: sel_o is %b, expected %b", $time, got, want);
            abort_run("byte select mismatch");
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run("control signal mismatch");
        end
    endtask

    function automatic bridge_pkg::ascii_t digit_char(logic [3:0] n, logic lower);
        string up = "0123456789ABCDEF";
        string lo = "0123456789abcdef";
        return lower ? lo[n] : up[n];
    endfunction

    function automatic bridge_pkg::ascii_t noise_char();
        bridge_pkg::ascii_t c;
        c = bridge_pkg::ascii_t'($urandom_range(32, 126));
        if (c == "?") begin
            c = "#";
        end
        return c;
    endfunction

    function automatic bridge_pkg::ascii_t bad_letter();
        bridge_pkg::ascii_t c;
        c = bridge_pkg::ascii_t'($urandom_range(33, 126));
        if (c == "r" || c == "w") begin
            c = "x";
        end
        return c;
    endfunction

    function automatic bridge_pkg::ascii_t non_hex_char();
        string pool = "gGxzk?:@ /!";
        return pool[$urandom_range(0, 10)];
    endfunction

    task automatic push_text(string s);
        for (int i = 0; i < s.len(); i++) begin
            exp_q.push_back(s[i]);
        end
    endtask

    // address pattern mixes high and low bytes
    task automatic fill_memory();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = bridge_pkg::bus_data_t'((a * 37 + (a >> 8)) ^ (a >> 11));
        end
    endtask

    task automatic send_line(bridge_pkg::ascii_t line[$]);
        @(negedge clk_i);
        sending = 1'b1;
        foreach (line[i]) begin
            if ($urandom_range(0, 3) == 0) begin
                rx_valid_i = 1'b0;
                @(negedge clk_i);
            end
            rx_byte_i  = line[i];
            rx_valid_i = 1'b1;
            while (!rx_ready_o) begin
                @(negedge clk_i);
            end
            @(negedge clk_i);
        end
        rx_valid_i = 1'b0;
        sending    = 1'b0;
    endtask

    // parser must stay blocked until the newline goes out
    task automatic wait_reply();
        while (exp_q.size() != 0) begin
            check_flag("rx_ready_o", rx_ready_o, 1'b0);
            @(negedge clk_i);
        end
    endtask

    task automatic run_command();
        bridge_pkg::ascii_t    line[$];
        bridge_pkg::bus_addr_t addr;
        bridge_pkg::bus_data_t data;
        logic [23:0]           digits;
        logic                  lower;
        logic                  is_write;
        int                    kind;
        int                    nibbles;
        int                    bad_pos;
        int                    num_noise;

        kind      = int'($urandom_range(0, 9));
        num_noise = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
        for (int i = 0; i < num_noise; i++) begin
            line.push_back(noise_char());
        end
        line.push_back("?");
        if (kind == 0) begin
            line.push_back(bad_letter());
            push_text("cmd err!");
        end else begin
            is_write = ($urandom_range(0, 1) == 1);
            addr     = bridge_pkg::bus_addr_t'($urandom_range(0, 65535));
            data     = bridge_pkg::bus_data_t'($urandom_range(0, 255));
            lower    = ($urandom_range(0, 1) == 1);
            if (!is_write && have_write && $urandom_range(0, 2) == 0) begin
                addr = last_write_addr;
            end
            line.push_back(is_write ? "w" : "r");
            nibbles = is_write ? 6 : 4;
            bad_pos = (kind == 1) ? int'($urandom_range(0, nibbles - 1)) : nibbles;
            digits  = {addr, data};
            for (int i = 0; i < nibbles && i <= bad_pos; i++) begin
                if (i == bad_pos) begin
                    line.push_back(non_hex_char());
                end else begin
                    line.push_back(digit_char(digits[23-4*i -: 4], lower));
                end
            end
            if (kind == 1) begin
                push_text("hex only!");
            end else begin
                bus_expected = 1'b1;
                exp_we       = is_write;
                exp_adr      = addr;
                exp_dat      = data;
                if (addr[15:12] == 4'hF) begin
                    push_text("no resp!");
                end else if (is_write) begin
                    mem[addr]       = data;
                    have_write      = 1'b1;
                    last_write_addr = addr;
                    push_text("OK");
                end else begin
                    exp_q.push_back(digit_char(mem[addr][7:4], 1'b0));
                    exp_q.push_back(digit_char(mem[addr][3:0], 1'b0));
                end
            end
        end
        exp_q.push_back(8'h0a);
        send_line(line);
        wait_reply();
        if (bus_expected) begin
            abort_run("command finished without a bus cycle");
        end
    endtask

    // reply side with random back-pressure
    always @(negedge clk_i) begin
        if (!rst_i) begin
            tx_ready_i = ($urandom_range(0, 3) != 0);
            if (tx_valid_o && tx_ready_i) begin
                if (sending) begin
                    abort_run("reply byte sent before the command line was complete");
                end else if (exp_q.size() == 0) begin
                    abort_run("reply byte sent while no reply was expected");
                end else begin
                    check_char(tx_byte_o, exp_q.pop_front());
                end
            end
        end
    end

    // Wishbone slave, addresses 0xF000 and up never ack
    always @(negedge clk_i) begin
        if (ack_i) begin
            ack_i = 1'b0;
            dat_i = bridge_pkg::bus_data_t'($urandom_range(0, 255));
        end else if (cyc_o && stb_o) begin
            if (!slave_busy && !bus_expected) begin
                abort_run("bus cycle started while no transfer was expected");
            end else begin
                if (!slave_busy) begin
                    // one transfer per command line
                    bus_expected = 1'b0;
                    slave_busy   = 1'b1;
                    ack_delay    = int'($urandom_range(0, 3));
                    check_flag("we_o", we_o, exp_we);
                    check_sel(sel_o);
                    check_bus_addr(adr_o, exp_adr);
                end
                if (adr_o[15:12] != 4'hF) begin
                    if (ack_delay == 0) begin
                        if (we_o) begin
                            check_bus_write(adr_o, dat_o, exp_adr, exp_dat);
                        end else begin
                            dat_i = mem[adr_o];
                        end
                        ack_i      = 1'b1;
                        slave_busy = 1'b0;
                    end else begin
                        ack_delay--;
                    end
                end
            end
        end else begin
            slave_busy = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        seed_ret        = $urandom(RAND_SEED);
        rst_i           = 1'b1;
        rx_byte_i       = '0;
        rx_valid_i      = 1'b0;
        tx_ready_i      = 1'b0;
        dat_i           = '0;
        ack_i           = 1'b0;
        cycles          = 0;
        error_count     = 0;
        sending         = 1'b0;
        bus_expected    = 1'b0;
        exp_we          = 1'b0;
        exp_adr         = '0;
        exp_dat         = '0;
        slave_busy      = 1'b0;
        ack_delay       = 0;
        have_write      = 1'b0;
        last_write_addr = '0;
        fill_memory();

        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        check_flag("rx_ready_o", rx_ready_o, 1'b1);
        check_flag("tx_valid_o", tx_valid_o, 1'b0);
        check_flag("cyc_o", cyc_o, 1'b0);
        check_flag("stb_o", stb_o, 1'b0);
        check_flag("we_o", we_o, 1'b0);

        for (int n = 0; n < NUM_CMDS; n++) begin
            run_command();
        end
        // stray output after the last reply is caught by the monitor
        repeat (20) @(negedge clk_i);

        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "errors were reported");
        end
    end

endmodule

/* verilog.f */
rtl/bridge_pkg.sv
rtl/command_parser.sv
rtl/wb_single_master.sv
rtl/reply_writer.sv
rtl/wb_debug_bridge.sv
testbench/tb_wb_debug_bridge.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_wb_debug_bridge \
    --Mdir obj_dir \
    -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_wb_debug_bridge
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
